/* sources.f */
+incdir+.
alu_op_pkg.sv
alu_data_pkg.sv
alu_fixed_point.sv
alu_bit_ops.sv
alu_transpose.sv
alu_top.sv
tb_alu_top.sv

/* Bender.yml */
package:
  name: alu_fixed_point_q6_10

sources:
  - include_dirs:
      - .
    files:
      - alu_op_pkg.sv
      - alu_data_pkg.sv
      - alu_fixed_point.sv
      - alu_bit_ops.sv
      - alu_transpose.sv
      - alu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_alu_top.sv

/* tb_alu_top.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module tb_alu_top;

    localparam int DW         = `ALU_DATA_W;
    localparam int CW         = `ALU_CELL_W;
    localparam int N          = `ALU_MAT_N;
    localparam int CLK_PERIOD = 8;
    localparam int N_ADDSUB   = 40;
    localparam int N_CORNER   = 8;  // Pairs run both as add and as sub
    localparam int N_MAC_RAND = 20; // Ops in each of two random MAC batches
    localparam int N_MAC_POS  = 56; // MIN*MIN drives acc into ACC_MAX
    localparam int N_MAC_NEG  = 70; // MAX*MIN walks acc down to ACC_MIN
    localparam int N_BITS     = 30;
    localparam int N_XP       = 3;
    localparam int N_OPS      = N_ADDSUB + 2 * N_CORNER + 2 * N_MAC_RAND + N_MAC_POS
                                + N_MAC_NEG + N_BITS + 3 + 9 + N_XP * N;

    localparam logic signed [DW-1:0] CORNER_A [N_CORNER] = '{
        alu_data_pkg::WORD_MAX, alu_data_pkg::WORD_MIN, alu_data_pkg::WORD_MAX,
        alu_data_pkg::WORD_MIN, alu_data_pkg::WORD_MAX, alu_data_pkg::WORD_MIN,
        16'sd0, -16'sd1};
    localparam logic signed [DW-1:0] CORNER_B [N_CORNER] = '{
        alu_data_pkg::WORD_MAX, alu_data_pkg::WORD_MIN, alu_data_pkg::WORD_MIN,
        alu_data_pkg::WORD_MAX, 16'sd1, 16'sd1,
        alu_data_pkg::WORD_MIN, alu_data_pkg::WORD_MAX};

    logic                 i_clk;
    logic                 i_rst_n;
    logic                 i_in_valid;
    alu_op_pkg::alu_op_e  i_inst;
    logic signed [DW-1:0] i_data_a;
    logic signed [DW-1:0] i_data_b;
    logic                 o_busy;
    logic                 o_out_valid;
    logic [DW-1:0]        o_data;

    // Expectations for the next sampling edge
    logic          exp_vld;
    logic          exp_busy;
    logic [DW-1:0] exp_dat;
    longint        acc_model; // Reference accumulator, Q16.20

    alu_top alu_top_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .i_inst      (i_inst),
        .i_data_a    (i_data_a),
        .i_data_b    (i_data_b),
        .o_busy      (o_busy),
        .o_out_valid (o_out_valid),
        .o_data      (o_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // ==============================
    // Reference model
    // ==============================

    function automatic logic [DW-1:0] sat16(input longint v);
        if (v > longint'(alu_data_pkg::WORD_MAX)) return alu_data_pkg::WORD_MAX;
        if (v < longint'(alu_data_pkg::WORD_MIN)) return alu_data_pkg::WORD_MIN;
        return v[DW-1:0];
    endfunction

    function automatic logic [DW-1:0] model_result(input alu_op_pkg::alu_op_e op,
                                                   input logic signed [DW-1:0] a,
                                                   input logic signed [DW-1:0] b);
        longint        sum;
        int            sh;
        logic [DW-1:0] r;
        r  = '0; // Retired and unknown codes
        sh = int'(b[3:0]); // Rotate ignores B above bit 3
        case (op)
            alu_op_pkg::OP_ADD: r = sat16(longint'(a) + longint'(b));
            alu_op_pkg::OP_SUB: r = sat16(longint'(a) - longint'(b));
            alu_op_pkg::OP_MAC: begin
                sum = acc_model + longint'(a) * longint'(b);
                // Half up adds bit 9 to the truncated value
                r = sat16((sum >>> `ALU_FRAC_W) + ((sum >>> (`ALU_FRAC_W - 1)) & 64'sd1));
                if (sum > longint'(alu_data_pkg::ACC_MAX)) sum = alu_data_pkg::ACC_MAX;
                if (sum < longint'(alu_data_pkg::ACC_MIN)) sum = alu_data_pkg::ACC_MIN;
                acc_model = sum;
            end
            alu_op_pkg::OP_GRAY: begin
                for (int i = 0; i < DW; i++) begin
                    r[i] = a[i] ^ ((i == DW - 1) ? 1'b0 : a[i+1]); // Top bit passes through
                end
            end
            alu_op_pkg::OP_ROR: begin
                for (int i = 0; i < DW; i++) begin
                    r[i] = a[(i + sh) % DW];
                end
            end
            alu_op_pkg::OP_CLZ: begin
                r = DW;
                for (int i = 0; i < DW; i++) begin
                    if (a[i]) r = DW - 1 - i; // Highest set bit wins
                end
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic signed [DW-1:0] rand_word();
        return DW'($urandom);
    endfunction

    // ==============================
    // Stimulus tasks
    // ==============================

    task automatic run_op(input alu_op_pkg::alu_op_e op,
                          input logic signed [DW-1:0] a,
                          input logic signed [DW-1:0] b);
        logic [DW-1:0] expect_w;
        @(posedge i_clk);
        i_in_valid <= 1'b1;
        i_inst     <= op;
        i_data_a   <= a;
        i_data_b   <= b;
        @(posedge i_clk); // Accepted on this edge
        expect_w = model_result(op, a, b);
        exp_vld    <= 1'b1;
        exp_busy   <= 1'b1;
        exp_dat    <= expect_w;
        i_in_valid <= 1'($urandom_range(0, 1)); // Offered while busy and must be dropped
        i_inst     <= alu_op_pkg::OP_MAC;
        i_data_a   <= rand_word();
        i_data_b   <= rand_word();
        @(posedge i_clk);
        exp_vld    <= 1'b0;
        exp_busy   <= 1'b0;
        i_in_valid <= 1'b0;
    endtask

    task automatic run_transpose();
        logic [DW-1:0] cols [N];
        logic [DW-1:0] rows [N];
        int            gap;
        for (int c = 0; c < N; c++) begin
            cols[c] = rand_word();
        end
        // Row r element c comes from column c element r with element 0 on top
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                rows[r][DW-1-CW*c -: CW] = cols[c][DW-1-CW*r -: CW];
            end
        end
        for (int c = 0; c < N; c++) begin
            gap = (c == 0) ? 0 : $urandom_range(0, 2);
            repeat (gap) begin
                @(posedge i_clk);
                i_in_valid <= 1'b0; // Idle between column words
            end
            @(posedge i_clk);
            i_in_valid <= 1'b1;
            i_inst     <= alu_op_pkg::OP_TRANSPOSE;
            i_data_a   <= cols[c];
            i_data_b   <= rand_word();
        end
        // k = 0 is the edge taking column 7
        for (int k = 0; k < N + 2; k++) begin
            @(posedge i_clk);
            exp_busy   <= (k < N);
            exp_vld    <= (k >= 1 && k <= N);
            if (k >= 1 && k <= N) begin
                exp_dat <= rows[k-1];
            end
            i_in_valid <= (k < N); // Restart attempts during readout
            i_data_a   <= rand_word();
        end
    endtask

    // ==============================
    // Checks
    // ==============================

    a_valid_match: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_out_valid == exp_vld
    ) else begin
        $display("Error at %0t: o_out_valid expected %0b got %0b", $time,
                 $sampled(exp_vld), $sampled(o_out_valid));
        $display(">>> FAIL");
        $fatal(1, "output valid mismatch");
    end

    a_data_match: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) exp_vld |-> (o_data == exp_dat)
    ) else begin
        $display("Error at %0t: o_data expected 0x%04h got 0x%04h", $time,
                 $sampled(exp_dat), $sampled(o_data));
        $display(">>> FAIL");
        $fatal(1, "output data mismatch");
    end

    a_busy_match: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) o_busy == exp_busy
    ) else begin
        $display("Error at %0t: o_busy expected %0b got %0b (dispatch %s)", $time,
                 $sampled(exp_busy), $sampled(o_busy), alu_top_inst.state_q.name());
        $display(">>> FAIL");
        $fatal(1, "busy mismatch");
    end

    initial begin
        #(N_OPS * 20 * CLK_PERIOD);
        $display("Run timed out after %0d cycles", N_OPS * 20);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        void'($urandom(48109));
        i_rst_n    = 1'b0;
        i_in_valid = 1'b0;
        i_inst     = alu_op_pkg::OP_ADD;
        i_data_a   = '0;
        i_data_b   = '0;
        exp_vld    = 1'b0;
        exp_busy   = 1'b0;
        exp_dat    = '0;
        acc_model  = 0;
        repeat (2) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (4) @(posedge i_clk); // Outputs must stay quiet here

        for (int i = 0; i < N_ADDSUB; i++) begin
            run_op($urandom_range(0, 1) ? alu_op_pkg::OP_SUB : alu_op_pkg::OP_ADD,
                   rand_word(), rand_word());
        end
        for (int i = 0; i < N_CORNER; i++) begin
            run_op(alu_op_pkg::OP_ADD, CORNER_A[i], CORNER_B[i]);
            run_op(alu_op_pkg::OP_SUB, CORNER_A[i], CORNER_B[i]);
        end

        // Small operands keep the rounded output unsaturated
        for (int i = 0; i < N_MAC_RAND; i++) begin
            run_op(alu_op_pkg::OP_MAC, DW'($urandom_range(0, 511)) - 16'sd256,
                   DW'($urandom_range(0, 511)) - 16'sd256);
        end
        repeat (N_MAC_POS) run_op(alu_op_pkg::OP_MAC, alu_data_pkg::WORD_MIN,
                                  alu_data_pkg::WORD_MIN);
        repeat (N_MAC_NEG) run_op(alu_op_pkg::OP_MAC, alu_data_pkg::WORD_MAX,
                                  alu_data_pkg::WORD_MIN);
        for (int i = 0; i < N_MAC_RAND; i++) begin
            run_op(alu_op_pkg::OP_MAC, rand_word(), rand_word());
        end

        for (int i = 0; i < N_BITS; i++) begin
            run_op((i % 3 == 0) ? alu_op_pkg::OP_GRAY :
                   (i % 3 == 1) ? alu_op_pkg::OP_ROR : alu_op_pkg::OP_CLZ,
                   rand_word() >> $urandom_range(0, 15), rand_word());
        end
        run_op(alu_op_pkg::OP_CLZ, 16'sd0, 16'sd0);     // Zero counts as 16
        run_op(alu_op_pkg::OP_ROR, -16'sd32767, 16'sd21); // Wraps to a shift of 5
        run_op(alu_op_pkg::OP_CLZ, 16'sd1, 16'sd0);

        // Retired and unknown codes
        for (int code = 3; code < 16; code++) begin
            if (code != 4 && code != 6 && code != 7 && code != 9) begin
                run_op(alu_op_pkg::alu_op_e'(4'(code)), rand_word(), rand_word());
            end
        end

        repeat (N_XP) run_transpose();

        repeat (3) @(posedge i_clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* alu_top.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_top (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_in_valid,
    input  alu_op_pkg::alu_op_e            i_inst,
    input  logic signed [`ALU_DATA_W-1:0]  i_data_a,
    input  logic signed [`ALU_DATA_W-1:0]  i_data_b,
    output logic                           o_busy,
    output logic                           o_out_valid,
    output logic [`ALU_DATA_W-1:0]         o_data
);

    localparam int DW    = `ALU_DATA_W;
    localparam int IDX_W = $clog2(`ALU_MAT_N);
    localparam logic [IDX_W-1:0] LAST_COL = IDX_W'(`ALU_MAT_N - 1);

    alu_op_pkg::alu_state_e state_q;

    logic             ready;
    logic             accept;
    logic             accept_xp;   // Transpose start, column 0
    logic             accept_op;   // Everything else, one-cycle result
    logic [DW-1:0]    fp_result;
    logic [DW-1:0]    bit_result;
    logic [DW-1:0]    sel_result;
    logic [DW-1:0]    result_q;
    logic             out_valid_q;
    logic             xp_active;
    logic             xp_row_valid;
    logic             xp_load_q;   // Buffer still collecting columns
    logic [IDX_W-1:0] xp_cols_q;

    alu_data_pkg::alu_word_u a_u;
    alu_data_pkg::alu_word_u b_u;
    alu_data_pkg::alu_word_u fp_res_u;
    alu_data_pkg::alu_word_u row_u;

    // ==============================
    // Accept and units
    // ==============================

    assign ready     = (state_q == alu_op_pkg::IDLE) && !xp_active;
    assign accept    = i_in_valid && ready;
    assign accept_xp = accept && (i_inst == alu_op_pkg::OP_TRANSPOSE);
    assign accept_op = accept && (i_inst != alu_op_pkg::OP_TRANSPOSE);

    assign a_u = i_data_a;
    assign b_u = i_data_b;

    alu_fixed_point u_fixed_point (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (accept),
        .i_op     (i_inst),
        .i_data_a (a_u),
        .i_data_b (b_u),
        .o_result (fp_res_u)
    );

    assign fp_result = fp_res_u;

    alu_bit_ops u_bit_ops (
        .i_op     (i_inst),
        .i_data_a (i_data_a),
        .i_data_b (i_data_b),
        .o_result (bit_result)
    );

    alu_transpose u_transpose (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_start_transpose (accept_xp),
        .i_col_valid       (i_in_valid), // Buffer only listens in its input phase
        .i_data_a          (a_u),
        .o_active          (xp_active),
        .o_row_valid       (xp_row_valid),
        .o_row             (row_u)
    );

    always_comb begin
        case (i_inst)
            alu_op_pkg::OP_ADD,
            alu_op_pkg::OP_SUB,
            alu_op_pkg::OP_MAC:  sel_result = fp_result;
            alu_op_pkg::OP_GRAY,
            alu_op_pkg::OP_ROR,
            alu_op_pkg::OP_CLZ:  sel_result = bit_result;
            default:             sel_result = '0; // Retired and unknown codes
        endcase
    end

    // ==============================
    // Dispatch and result register
    // ==============================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= alu_op_pkg::IDLE;
            out_valid_q <= 1'b0;
            result_q    <= '0;
        end else begin
            out_valid_q <= accept_op;
            state_q     <= accept_op ? alu_op_pkg::BUSY : alu_op_pkg::IDLE;
            if (accept_op) begin
                result_q <= sel_result;
            end
        end
    end

    // Column tracking, busy stays low while columns trickle in
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            xp_load_q <= 1'b0;
            xp_cols_q <= '0;
        end else if (accept_xp) begin
            xp_load_q <= 1'b1;
            xp_cols_q <= IDX_W'(1);
        end else if (xp_load_q && i_in_valid) begin
            xp_cols_q <= xp_cols_q + 1'b1;
            if (xp_cols_q == LAST_COL) begin
                xp_load_q <= 1'b0; // Readout begins next cycle
            end
        end
    end

    assign o_busy      = (state_q == alu_op_pkg::BUSY) || (xp_active && !xp_load_q);
    assign o_out_valid = out_valid_q || xp_row_valid;
    assign o_data      = xp_row_valid ? DW'(row_u) : result_q;

    a_valid_exclusive: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(out_valid_q && xp_row_valid)
    ) else $error("single-cycle result collides with transpose row");

    // Last transpose row trails busy by one cycle
    a_valid_busy: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_out_valid |-> (o_busy || $past(o_busy))
    ) else $error("output valid without busy, state %s", state_q.name());

endmodule

/* alu_transpose.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_transpose (
    input  logic                     i_clk,
    input  logic                     i_rst_n,
    input  logic                     i_start_transpose, // Column 0 on i_data_a
    input  logic                     i_col_valid,       // Columns 1..7 during capture
    input  alu_data_pkg::alu_word_u  i_data_a,
    output logic                     o_active,
    output logic                     o_row_valid,
    output alu_data_pkg::alu_word_u  o_row
);

    localparam int N     = `ALU_MAT_N;
    localparam int IDX_W = $clog2(N);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(N - 1);

    // Row-major storage with rows_q[r].cells[c] holding column c element r
    alu_data_pkg::alu_word_u rows_q [N];

    logic              in_phase_q;   // Waiting for columns 1..7
    logic              rd_phase_q;   // Streaming rows out
    logic [IDX_W-1:0]  col_cnt_q;
    logic [IDX_W-1:0]  row_cnt_q;
    logic              row_valid_q;
    logic              col_wr;
    logic [IDX_W-1:0]  wr_col;
    alu_data_pkg::alu_word_u row_q;

    // ==============================
    // Column capture
    // ==============================

    assign col_wr = i_start_transpose || (in_phase_q && i_col_valid);
    assign wr_col = i_start_transpose ? '0 : col_cnt_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < N; r++) begin
                rows_q[r] <= '0;
            end
        end else if (col_wr) begin
            // Scatter one column across all rows
            for (int r = 0; r < N; r++) begin
                rows_q[r].cells[wr_col] <= i_data_a.cells[r];
            end
        end
    end

    // ==============================
    // Phase control
    // ==============================

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in_phase_q  <= 1'b0;
            rd_phase_q  <= 1'b0;
            col_cnt_q   <= '0;
            row_cnt_q   <= '0;
            row_valid_q <= 1'b0;
        end else begin
            row_valid_q <= rd_phase_q; // Row register lags readout by one
            if (i_start_transpose) begin
                in_phase_q <= 1'b1;
                col_cnt_q  <= IDX_W'(1); // Column 0 taken with the start
            end else if (in_phase_q && i_col_valid) begin
                col_cnt_q <= col_cnt_q + 1'b1;
                if (col_cnt_q == LAST) begin
                    in_phase_q <= 1'b0; // Flip to readout after the last column
                    rd_phase_q <= 1'b1;
                end
            end
            if (rd_phase_q) begin
                row_cnt_q <= row_cnt_q + 1'b1; // Wraps back to row 0
                if (row_cnt_q == LAST) begin
                    rd_phase_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_phase_q) begin
            row_q <= rows_q[row_cnt_q];
        end
    end

    assign o_active    = in_phase_q || rd_phase_q;
    assign o_row_valid = row_valid_q;
    assign o_row       = row_q;

    // Top must hold off a new transpose until this one has drained
    a_no_restart: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_start_transpose && o_active)
    ) else $error("transpose started while buffer active");

    // Eight rows bring the counter back to row 0 as readout ends
    a_row_cnt_idle: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !rd_phase_q |-> (row_cnt_q == '0)
    ) else $error("row counter away from row 0 outside readout");

endmodule

/* alu_bit_ops.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_bit_ops (
    input  alu_op_pkg::alu_op_e     i_op,
    input  logic [`ALU_DATA_W-1:0]  i_data_a,
    input  logic [`ALU_DATA_W-1:0]  i_data_b,
    output logic [`ALU_DATA_W-1:0]  o_result
);

    localparam int DW = `ALU_DATA_W;
    localparam int SW = $clog2(DW); // Rotate amount width

    logic [DW-1:0]   gray;
    logic [2*DW-1:0] rot_wide;   // A doubled so the shift wraps
    logic [DW-1:0]   rot;
    logic [DW-1:0]   clz;

    // Zeros above the first set bit, full width for zero input
    function automatic logic [DW-1:0] count_lz(input logic [DW-1:0] v);
        logic [DW-1:0] n;
        logic          seen;
        n    = '0;
        seen = 1'b0;
        for (int i = DW - 1; i >= 0; i--) begin
            seen = seen | v[i];
            if (!seen) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign gray = i_data_a ^ (i_data_a >> 1); // Adjacent bit differences

    // Only B[3:0] counts, larger amounts wrap mod 16
    assign rot_wide = {i_data_a, i_data_a} >> i_data_b[SW-1:0];
    assign rot      = rot_wide[DW-1:0];

    assign clz = count_lz(i_data_a);

    always_comb begin
        case (i_op)
            alu_op_pkg::OP_GRAY: o_result = gray;
            alu_op_pkg::OP_ROR:  o_result = rot;
            alu_op_pkg::OP_CLZ:  o_result = clz;
            default:             o_result = '0;
        endcase
    end

endmodule

/* alu_fixed_point.sv */
`timescale 1ns/100ps

`include "alu_settings.svh"

module alu_fixed_point (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,  // Op accepted this cycle
    input  alu_op_pkg::alu_op_e       i_op,
    input  alu_data_pkg::alu_word_u   i_data_a,
    input  alu_data_pkg::alu_word_u   i_data_b,
    output alu_data_pkg::alu_word_u   o_result
);

    localparam int DW  = `ALU_DATA_W;
    localparam int FW  = `ALU_FRAC_W;
    localparam int AW  = `ALU_ACC_W;
    localparam int RW  = AW - FW + 1; // Rounded MAC sum from the integer part of 37 bits

    logic signed [DW-1:0]   a_s;        // Operands as plain signed words
    logic signed [DW-1:0]   b_s;
    logic signed [DW:0]     addsub;     // One guard bit for overflow
    logic signed [2*DW-1:0] prod;       // Q12.20 product
    logic signed [AW:0]     acc_sum;    // Unsaturated accumulator + product
    logic signed [RW-1:0]   mac_round;
    logic                   mac_start;
    logic [DW-1:0]          res_w;

    alu_data_pkg::alu_acc_t acc_q;
    alu_data_pkg::alu_acc_t acc_next;

    // Clamp a wide signed value to the 16-bit range
    function automatic logic [DW-1:0] sat_word(input logic signed [RW-1:0] v);
        if (v > alu_data_pkg::WORD_MAX) begin
            return alu_data_pkg::WORD_MAX;
        end else if (v < alu_data_pkg::WORD_MIN) begin
            return alu_data_pkg::WORD_MIN;
        end
        return v[DW-1:0];
    endfunction

    // ==============================
    // Add / subtract
    // ==============================

    assign a_s = {i_data_a.fixed.int_part, i_data_a.fixed.frac};
    assign b_s = {i_data_b.fixed.int_part, i_data_b.fixed.frac};

    assign addsub = (i_op == alu_op_pkg::OP_SUB) ? a_s - b_s : a_s + b_s;

    // ==============================
    // Multiply-accumulate
    // ==============================

    assign prod    = a_s * b_s;    // Binary point at bit 20 as in acc
    assign acc_sum = acc_q + prod; // Sign-extended to 37 bits

    // Accumulator path saturates at 36 bits
    always_comb begin
        if (acc_sum > alu_data_pkg::ACC_MAX) begin
            acc_next = alu_data_pkg::ACC_MAX;
        end else if (acc_sum < alu_data_pkg::ACC_MIN) begin
            acc_next = alu_data_pkg::ACC_MIN;
        end else begin
            acc_next = acc_sum[AW-1:0];
        end
    end

    // Output path works on the unsaturated sum
    // Bit 9 set means fraction >= one half and rounds up
    assign mac_round = $signed(acc_sum[AW:FW]) + $signed({1'b0, acc_sum[FW-1]});

    assign mac_start = i_start && (i_op == alu_op_pkg::OP_MAC);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q <= '0;
        end else if (mac_start) begin
            acc_q <= acc_next; // Keeps running until reset
        end
    end

    // ==============================
    // Result select
    // ==============================

    always_comb begin
        case (i_op)
            alu_op_pkg::OP_ADD,
            alu_op_pkg::OP_SUB: res_w = sat_word(addsub);
            alu_op_pkg::OP_MAC: res_w = sat_word(mac_round);
            default:            res_w = '0; // Not an arithmetic op
        endcase
    end

    assign o_result = alu_data_pkg::alu_word_u'(res_w);

    // Accumulator moves with the product sign and never wraps
    a_acc_no_wrap: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        mac_start |=> ($past(prod[2*DW-1]) ? ($signed(acc_q) <= $signed($past(acc_q)))
                                           : ($signed(acc_q) >= $signed($past(acc_q))))
    ) else $error("accumulator wrapped past its limits");

endmodule

/* alu_data_pkg.sv */
`include "alu_settings.svh"

package alu_data_pkg;

    // ==============================
    // Word views
    // ==============================

    // Fixed-point reading, integer part carries the sign
    typedef struct packed {
        logic signed [`ALU_DATA_W-`ALU_FRAC_W-1:0] int_part;
        logic        [`ALU_FRAC_W-1:0]             frac;
    } alu_fixed_t;

    // Same 16 bits seen as arithmetic operand or as one matrix column/row
    typedef union packed {
        alu_fixed_t                                   fixed;
        logic [0:`ALU_MAT_N-1][`ALU_CELL_W-1:0] cells; // Element 0 in the top bits
    } alu_word_u;

    // Accumulator, Q16.20
    typedef logic signed [`ALU_ACC_W-1:0] alu_acc_t;

    // ==============================
    // Saturation limits
    // ==============================

    localparam logic signed [`ALU_DATA_W-1:0] WORD_MAX = {1'b0, {(`ALU_DATA_W-1){1'b1}}};
    localparam logic signed [`ALU_DATA_W-1:0] WORD_MIN = {1'b1, {(`ALU_DATA_W-1){1'b0}}};

    localparam alu_acc_t ACC_MAX = {1'b0, {(`ALU_ACC_W-1){1'b1}}}; // 2^35 - 1
    localparam alu_acc_t ACC_MIN = {1'b1, {(`ALU_ACC_W-1){1'b0}}}; // -2^35

endpackage

/* alu_op_pkg.sv */
package alu_op_pkg;

    // ==============================
    // Instruction encoding
    // ==============================

    // Codes 3, 5 and 8 are retired and decode as zero-result ops
    typedef enum logic [3:0] {
        OP_ADD       = 4'd0, // Saturating add
        OP_SUB       = 4'd1, // Saturating subtract
        OP_MAC       = 4'd2, // Multiply-accumulate
        OP_GRAY      = 4'd4, // Binary to Gray
        OP_ROR       = 4'd6, // Rotate right by B[3:0]
        OP_CLZ       = 4'd7, // Leading zeros from MSB
        OP_TRANSPOSE = 4'd9  // 8x8 matrix of 2-bit cells
    } alu_op_e;

    // ==============================
    // Dispatch FSM
    // ==============================

    typedef enum logic {
        IDLE = 1'b0, // Ready for a new op
        BUSY = 1'b1  // Single-cycle result on the output
    } alu_state_e;

endpackage

/* alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// ==============================
// Datapath widths
// ==============================

// Operand and result word, signed Q6.10
`define ALU_DATA_W 16

// Fraction bits of the Q6.10 word
`define ALU_FRAC_W 10

// MAC accumulator, signed Q16.20
`define ALU_ACC_W 36

// ==============================
// Transpose matrix
// ==============================

`define ALU_CELL_W 2 // Bits per matrix element

`define ALU_MAT_N 8 // Rows and columns, one word per column

`endif
